/* vlog.f */
source/dma_bus_pkg.sv
source/dma_fifo_pkg.sv
source/cpu_bus_sm.sv
source/dma_fifo.sv
source/word_packer.sv
source/dma_addr_count.sv
source/dma_top.sv
sim/bus_slave_model.sv
sim/tb_dma_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compiles the DMA write engine and its testbench with Verilator and runs it.
# Exits non-zero when the build fails, the run fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary -sv --assert --timescale 1ns/1ps \
    --top-module tb_dma_top -Mdir "$OBJ_DIR" -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_dma_top" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi

exit 0

/* sim/tb_dma_top.sv */
// testbench for the SCSI-to-memory DMA write engine
// feeds half words, lets a memory model answer the bus cycles and checks
// every long word written against a model built from the half words sent
`timescale 1ns/1ps

module tb_dma_top;

    localparam int unsigned SEED = 32'hbb65d08f;
    localparam int NUM_WORDS = 12;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SIG_DONE = 0;
    localparam int SIG_BGACK = 1;
    localparam int SIG_STOP = 2;
    localparam int SIG_FULL = 3;

    logic        BCLK;
    logic        CCRESET_;
    logic        scsi_wr;
    logic [15:0] scsi_data;
    logic        fifo_full;
    logic        flush;
    logic        stop_flush;
    logic        dma_ena;
    logic        load;
    logic [31:0] start_addr;
    logic [15:0] word_count;
    logic        dma_done;
    logic        breq;
    logic        bgrant_n;
    logic        bgack;
    logic        pas;
    logic        pds;
    logic [31:0] addr;
    logic [31:0] data_out;
    logic        dsack0_n;
    logic        dsack1_n;
    logic        sterm_n;
    logic        hold_grant;
    logic        wr_valid;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;

    string       test_name;
    logic [15:0] sent_halves[$];
    logic [31:0] base_addr;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic [31:0] last_data;
    int          words_due;
    int          idx_base;
    int          rel;
    int          write_idx = 0;
    int          write_errors = 0;
    int          check_errors = 0;
    int          timeouts = 0;

    dma_top u_dut (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .scsi_wr    (scsi_wr),
        .scsi_data  (scsi_data),
        .fifo_full  (fifo_full),
        .flush      (flush),
        .stop_flush (stop_flush),
        .dma_ena    (dma_ena),
        .load       (load),
        .start_addr (start_addr),
        .word_count (word_count),
        .dma_done   (dma_done),
        .breq       (breq),
        .bgrant_n   (bgrant_n),
        .bgack      (bgack),
        .pas        (pas),
        .pds        (pds),
        .addr       (addr),
        .data_out   (data_out),
        .dsack0_n   (dsack0_n),
        .dsack1_n   (dsack1_n),
        .sterm_n    (sterm_n)
    );

    bus_slave_model u_slave (
        .BCLK       (BCLK),
        .hold_grant (hold_grant),
        .breq       (breq),
        .bgack      (bgack),
        .pas        (pas),
        .pds        (pds),
        .addr       (addr),
        .data       (data_out),
        .bgrant_n   (bgrant_n),
        .dsack0_n   (dsack0_n),
        .dsack1_n   (dsack1_n),
        .sterm_n    (sterm_n),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    initial begin
        BCLK = 1'b0;
        forever #20 BCLK = ~BCLK;
    end

    // low half first, a missing high half reads as zero after a flush
    function automatic logic [31:0] expected_word(input int i);
        logic [15:0] lo;
        logic [15:0] hi;
        lo = (2 * i < sent_halves.size()) ? sent_halves[2 * i] : 16'h0000;
        hi = (2 * i + 1 < sent_halves.size()) ? sent_halves[2 * i + 1] : 16'h0000;
        return {hi, lo};
    endfunction

    function automatic bit value_ok(input string what, input logic [31:0] expected,
                                    input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
        return expected === actual;
    endfunction

    function automatic logic watch(input int sel);
        case (sel)
            SIG_DONE:  return dma_done;
            SIG_BGACK: return bgack;
            SIG_STOP:  return stop_flush;
            default:   return fifo_full;
        endcase
    endfunction

    // each logged write against the reference
    always @(posedge BCLK) begin
        if (wr_valid) begin
            rel      = write_idx - idx_base;
            exp_addr = base_addr + 32'(rel) * 32'd4;
            exp_data = expected_word(rel);
            assert (rel < words_due) else begin
                $display("%s: a write was seen after the last programmed word", test_name);
                write_errors++;
            end
            if (!value_ok("address", exp_addr, wr_addr)) begin
                write_errors++;
            end
            if (!value_ok("data", exp_data, wr_data)) begin
                write_errors++;
            end
            last_data = wr_data;
            write_idx++;
        end
    end

    task automatic report_and_finish();
        $display("errors: %0d write, %0d check, %0d timeout; writes seen: %0d",
                 write_errors, check_errors, timeouts, write_idx);
        if (write_errors + check_errors + timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (!value_ok(what, expected, actual)) begin
            check_errors++;
        end
    endtask

    task automatic wait_until(input string what, input int sel, input logic level);
        int cycles;
        cycles = 0;
        while (watch(sel) !== level) begin
            @(negedge BCLK);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                timeouts++;
                $display("%s: timed out waiting for %s", test_name, what);
                report_and_finish();
            end
        end
    endtask

    // one strobe per half word, held off while the FIFO is full
    task automatic send_half(input logic [15:0] value);
        int cycles;
        cycles = 0;
        while (fifo_full) begin
            scsi_wr = 1'b0;
            @(negedge BCLK);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                timeouts++;
                $display("%s: FIFO stayed full and the source could not send", test_name);
                report_and_finish();
            end
        end
        scsi_wr   = 1'b1;
        scsi_data = value;
        sent_halves.push_back(value);
        @(negedge BCLK);
        scsi_wr = 1'b0;
    endtask

    task automatic start_transfer(input string name, input int words);
        test_name  = name;
        base_addr  = $urandom() & 32'hffff_fffc;
        words_due  = words;
        idx_base   = write_idx;
        sent_halves.delete();
        start_addr = base_addr;
        word_count = 16'(words);
        load       = 1'b1;
        @(negedge BCLK);
        load       = 1'b0;
    endtask

    task automatic end_transfer(input int words);
        wait_until("dma_done", SIG_DONE, 1'b1);
        wait_until("bus release", SIG_BGACK, 1'b0);
        // quiet window, any write here is one too many
        repeat (8) @(negedge BCLK);
        check("write count", 32'(words), 32'(write_idx - idx_base));
    endtask

    initial begin
        int i;
        void'($urandom(SEED));
        CCRESET_   = 1'b0;
        scsi_wr    = 1'b0;
        scsi_data  = '0;
        flush      = 1'b0;
        dma_ena    = 1'b0;
        load       = 1'b0;
        start_addr = '0;
        word_count = '0;
        hold_grant = 1'b0;
        test_name  = "reset";
        base_addr  = '0;
        words_due  = 0;
        idx_base   = 0;
        repeat (2) @(negedge BCLK);
        CCRESET_ = 1'b1;
        @(negedge BCLK);
        check("breq", 32'd0, 32'(breq));
        check("bgack", 32'd0, 32'(bgack));
        check("pas", 32'd0, 32'(pas));
        check("pds", 32'd0, 32'(pds));
        check("stop_flush", 32'd0, 32'(stop_flush));
        check("fifo_full", 32'd0, 32'(fifo_full));
        check("dma_done", 32'd1, 32'(dma_done));

        dma_ena = 1'b1;
        start_transfer("random transfer", NUM_WORDS);
        for (i = 0; i < 2 * NUM_WORDS; i++) begin
            send_half(16'($urandom()));
        end
        end_transfer(NUM_WORDS);

        // fill the FIFO while the arbiter sits on the grant
        hold_grant = 1'b1;
        start_transfer("fifo full", 8);
        for (i = 0; i < 16; i++) begin
            send_half(16'($urandom()));
        end
        wait_until("fifo_full", SIG_FULL, 1'b1);
        check("writes before grant", 32'd0, 32'(write_idx - idx_base));
        check("breq while grant held", 32'd1, 32'(breq));
        hold_grant = 1'b0;
        end_transfer(8);

        dma_ena = 1'b0;
        start_transfer("dma disabled", 4);
        for (i = 0; i < 8; i++) begin
            send_half(16'($urandom()));
        end
        for (i = 0; i < 16; i++) begin
            @(negedge BCLK);
            check("breq while disabled", 32'd0, 32'(breq));
        end
        check("writes while disabled", 32'd0, 32'(write_idx - idx_base));
        dma_ena = 1'b1;
        end_transfer(4);

        // odd half count, the last word goes out padded
        start_transfer("flush", 3);
        for (i = 0; i < 5; i++) begin
            send_half(16'($urandom()));
        end
        flush = 1'b1;
        wait_until("stop_flush high", SIG_STOP, 1'b1);
        check("writes at stop_flush", 32'd3, 32'(write_idx - idx_base));
        check("padded upper half", 32'd0, 32'(last_data[31:16]));
        flush = 1'b0;
        wait_until("stop_flush low", SIG_STOP, 1'b0);
        end_transfer(3);

        report_and_finish();
    end

endmodule

/* sim/bus_slave_model.sv */
// memory responder for the DMA write engine
// grants the bus after a random delay, ends each write after random wait
// states with DSACK or STERM, and reports the write as a one-cycle pulse
`timescale 1ns/1ps

module bus_slave_model (
    input  logic        BCLK,
    input  logic        hold_grant,
    input  logic        breq,
    input  logic        bgack,
    input  logic        pas,
    input  logic        pds,
    input  logic [31:0] addr,
    input  logic [31:0] data,
    output logic        bgrant_n,
    output logic        dsack0_n,
    output logic        dsack1_n,
    output logic        sterm_n,
    output logic        wr_valid,
    output logic [31:0] wr_addr,
    output logic [31:0] wr_data
);

    int   gnt_delay;
    int   wait_states;
    logic acked;

    initial begin
        bgrant_n    = 1'b1;
        dsack0_n    = 1'b1;
        dsack1_n    = 1'b1;
        sterm_n     = 1'b1;
        wr_valid    = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        gnt_delay   = 0;
        wait_states = 0;
        acked       = 1'b0;
    end

    // outputs move on the falling edge, away from the DUT's sampling edge
    always @(negedge BCLK) begin
        wr_valid <= 1'b0;

        // grant withdrawn once the DMA owns the bus
        if (bgack) begin
            bgrant_n <= 1'b1;
        end else if (breq && !hold_grant) begin
            if (gnt_delay == 0) begin
                bgrant_n <= 1'b0;
            end else begin
                gnt_delay <= gnt_delay - 1;
            end
        end else begin
            bgrant_n  <= 1'b1;
            gnt_delay <= $urandom_range(0, 3);
        end

        // acknowledge held until the address strobe goes away
        if (!pas) begin
            dsack0_n    <= 1'b1;
            dsack1_n    <= 1'b1;
            sterm_n     <= 1'b1;
            acked       <= 1'b0;
            wait_states <= $urandom_range(0, 4);
        end else if (pds && !acked) begin
            if (wait_states != 0) begin
                wait_states <= wait_states - 1;
            end else begin
                if ($urandom_range(0, 1) == 0) begin
                    dsack0_n <= 1'b0;
                    dsack1_n <= 1'b0;
                end else begin
                    sterm_n <= 1'b0;
                end
                acked    <= 1'b1;
                wr_valid <= 1'b1;
                wr_addr  <= addr;
                wr_data  <= data;
            end
        end
    end

endmodule

/* source/dma_top.sv */
// SCSI-to-memory DMA write engine
// half words from the SCSI side are packed, queued and written to memory
// as 32-bit bus-master cycles at incrementing addresses
`timescale 1ns/1ps

module dma_top (
    input  logic                           BCLK,
    input  logic                           CCRESET_,
    input  logic                           scsi_wr,
    input  logic [dma_fifo_pkg::HALF_W-1:0] scsi_data,
    output logic                           fifo_full,
    input  logic                           flush,
    output logic                           stop_flush,
    input  logic                           dma_ena,
    input  logic                           load,
    input  logic [dma_bus_pkg::ADDR_W-1:0] start_addr,
    input  logic [dma_fifo_pkg::CNT_W-1:0] word_count,
    output logic                           dma_done,
    output logic                           breq,
    input  logic                           bgrant_n,
    output logic                           bgack,
    output logic                           pas,
    output logic                           pds,
    output logic [dma_bus_pkg::ADDR_W-1:0] addr,
    output logic [dma_bus_pkg::DATA_W-1:0] data_out,
    input  logic                           dsack0_n,
    input  logic                           dsack1_n,
    input  logic                           sterm_n
);

    logic                           fifo_empty;
    logic                           fifo_pop;
    logic                           step;
    logic                           push;
    logic [dma_bus_pkg::DATA_W-1:0] wdata;
    logic                           pending_half;
    logic                           flush_req;

    cpu_bus_sm u_cpu_bus_sm (
        .BCLK         (BCLK),
        .CCRESET_     (CCRESET_),
        .bgrant_n     (bgrant_n),
        .dsack0_n     (dsack0_n),
        .dsack1_n     (dsack1_n),
        .sterm_n      (sterm_n),
        .dma_ena      (dma_ena),
        .flush        (flush),
        .fifo_empty   (fifo_empty),
        .pending_half (pending_half),
        .dma_done     (dma_done),
        .breq         (breq),
        .bgack        (bgack),
        .pas          (pas),
        .pds          (pds),
        .fifo_pop     (fifo_pop),
        .step         (step),
        .flush_req    (flush_req),
        .stop_flush   (stop_flush)
    );

    word_packer u_word_packer (
        .BCLK         (BCLK),
        .CCRESET_     (CCRESET_),
        .scsi_wr      (scsi_wr),
        .scsi_data    (scsi_data),
        .flush_req    (flush_req),
        .full         (fifo_full),
        .push         (push),
        .wdata        (wdata),
        .pending_half (pending_half)
    );

    dma_fifo u_dma_fifo (
        .BCLK     (BCLK),
        .CCRESET_ (CCRESET_),
        .push     (push),
        .wdata    (wdata),
        .pop      (fifo_pop),
        .rdata    (data_out),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

    dma_addr_count u_dma_addr_count (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .load       (load),
        .start_addr (start_addr),
        .word_count (word_count),
        .step       (step),
        .addr       (addr),
        .dma_done   (dma_done)
    );

endmodule

/* source/dma_addr_count.sv */
// memory address and remaining-word counter of the DMA write path
// load takes the start address and length, each step moves on one long word
// dma_done stays high while no words remain
`timescale 1ns/1ps

module dma_addr_count (
    input  logic                           BCLK,
    input  logic                           CCRESET_,
    input  logic                           load,
    input  logic [dma_bus_pkg::ADDR_W-1:0] start_addr,
    input  logic [dma_fifo_pkg::CNT_W-1:0] word_count,
    input  logic                           step,
    output logic [dma_bus_pkg::ADDR_W-1:0] addr,
    output logic                           dma_done
);

    logic [dma_fifo_pkg::CNT_W-1:0] remain;

    // load wins over a step in the same cycle
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            addr   <= '0;
            remain <= '0;
        end else if (load) begin
            addr   <= start_addr;
            remain <= word_count;
        end else if (step) begin
            addr   <= addr + dma_bus_pkg::ADDR_STEP;
            remain <= remain - 1'b1;
        end
    end

    assign dma_done = (remain == '0);

    // the bus master must not write past the programmed length
    a_no_step_when_done: assert property (
        @(posedge BCLK) disable iff (!CCRESET_) step |-> !dma_done
    );

endmodule

/* source/word_packer.sv */
// joins SCSI half words into long words for the DMA FIFO
// first half of a pair goes to the low lane, second to the high lane
// a finished word waits here while the FIFO is full
// on flush a lone half leaves with the high lane zeroed
`timescale 1ns/1ps

module word_packer (
    input  logic                               BCLK,
    input  logic                               CCRESET_,
    input  logic                               scsi_wr,
    input  logic [dma_fifo_pkg::HALF_W-1:0]    scsi_data,
    input  logic                               flush_req,
    input  logic                               full,
    output logic                               push,
    output logic [dma_bus_pkg::DATA_W-1:0]     wdata,
    output logic                               pending_half
);

    logic [dma_fifo_pkg::HALF_W-1:0] low_q;
    logic [dma_fifo_pkg::HALF_W-1:0] high_q;
    logic have_low;
    logic word_rdy;
    logic pad;

    // lone half with nothing else queued here
    assign pad = flush_req && have_low && !word_rdy && !scsi_wr;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            have_low <= 1'b0;
            word_rdy <= 1'b0;
        end else begin
            if (push) begin
                word_rdy <= 1'b0;
            end
            if (scsi_wr) begin
                have_low <= !have_low;
                if (have_low) begin
                    word_rdy <= 1'b1;
                end
            end else if (pad) begin
                have_low <= 1'b0;
                word_rdy <= 1'b1;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (scsi_wr && !have_low) begin
            low_q <= scsi_data;
        end else if (scsi_wr) begin
            high_q <= scsi_data;
        end else if (pad) begin
            high_q <= '0;
        end
    end

    assign push         = word_rdy && !full;
    assign wdata        = {high_q, low_q};
    assign pending_half = have_low || word_rdy;

endmodule

/* source/dma_fifo.sv */
// long-word FIFO between the word packer and the bus master
// circular buffer with an occupancy count, head entry shown combinationally
// the writer must watch full and the reader must watch empty
`timescale 1ns/1ps

module dma_fifo (
    input  logic                           BCLK,
    input  logic                           CCRESET_,
    input  logic                           push,
    input  logic [dma_bus_pkg::DATA_W-1:0] wdata,
    input  logic                           pop,
    output logic [dma_bus_pkg::DATA_W-1:0] rdata,
    output logic                           empty,
    output logic                           full
);

    logic [dma_bus_pkg::DATA_W-1:0] mem [dma_fifo_pkg::FIFO_DEPTH];
    logic [dma_fifo_pkg::PTR_W-1:0] wr_ptr;
    logic [dma_fifo_pkg::PTR_W-1:0] rd_ptr;
    logic [dma_fifo_pkg::PTR_W:0]   count;

    always_ff @(posedge BCLK) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (dma_fifo_pkg::PTR_W + 1)'(dma_fifo_pkg::FIFO_DEPTH));

    a_no_overflow: assert property (
        @(posedge BCLK) disable iff (!CCRESET_) push |-> !full
    );

    a_no_underflow: assert property (
        @(posedge BCLK) disable iff (!CCRESET_) pop |-> !empty
    );

endmodule

/* source/cpu_bus_sm.sv */
// bus-master control of the DMA write path
// syncs the handshake inputs, requests the bus and runs one long-word
// write per FIFO entry until the FIFO drains or the count runs out
// every strobe comes straight from a flop
`timescale 1ns/1ps

module cpu_bus_sm (
    input  logic BCLK,
    input  logic CCRESET_,
    input  logic bgrant_n,
    input  logic dsack0_n,
    input  logic dsack1_n,
    input  logic sterm_n,
    input  logic dma_ena,
    input  logic flush,
    input  logic fifo_empty,
    input  logic pending_half,
    input  logic dma_done,
    output logic breq,
    output logic bgack,
    output logic pas,
    output logic pds,
    output logic fifo_pop,
    output logic step,
    output logic flush_req,
    output logic stop_flush
);

    // bits 5 to 0 carry bgrant_n dsack1_n dsack0_n sterm_n dma_ena flush
    logic [5:0] sync_1;
    logic [5:0] sync_2;
    logic grant;
    logic ack;
    logic ena;
    logic work;
    dma_bus_pkg::cpu_state_t state;

    // two-flop synchronizers, idle levels out of reset
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            sync_1 <= 6'b111100;
            sync_2 <= 6'b111100;
        end else begin
            sync_1 <= {bgrant_n, dsack1_n, dsack0_n, sterm_n, dma_ena, flush};
            sync_2 <= sync_1;
        end
    end

    assign grant     = !sync_2[5];
    assign ack       = (sync_2[4:3] == dma_bus_pkg::DSACK_32) || !sync_2[2];
    assign ena       = sync_2[1];
    assign flush_req = sync_2[0];

    // data waiting and words still owed
    assign work = ena && !fifo_empty && !dma_done;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state    <= dma_bus_pkg::IDLE;
            breq     <= 1'b0;
            bgack    <= 1'b0;
            pas      <= 1'b0;
            pds      <= 1'b0;
            fifo_pop <= 1'b0;
            step     <= 1'b0;
        end else begin
            fifo_pop <= 1'b0;
            step     <= 1'b0;
            case (state)
                dma_bus_pkg::IDLE: begin
                    if (work) begin
                        state <= dma_bus_pkg::REQ;
                        breq  <= 1'b1;
                    end
                end
                // arbiter gets a full cycle of breq before grant is looked at
                dma_bus_pkg::REQ: begin
                    state <= dma_bus_pkg::WAIT_GNT;
                end
                dma_bus_pkg::WAIT_GNT: begin
                    if (grant) begin
                        state <= dma_bus_pkg::OWN;
                        breq  <= 1'b0;
                        bgack <= 1'b1;
                    end
                end
                // bus held between cycles, fifo and count flags have settled
                dma_bus_pkg::OWN: begin
                    if (work) begin
                        state <= dma_bus_pkg::ADDR;
                        pas   <= 1'b1;
                    end else begin
                        state <= dma_bus_pkg::RELEASE;
                        bgack <= 1'b0;
                    end
                end
                // hold off until the last acknowledge has gone away
                dma_bus_pkg::ADDR: begin
                    if (!ack) begin
                        state <= dma_bus_pkg::DATA;
                        pds   <= 1'b1;
                    end
                end
                dma_bus_pkg::DATA: begin
                    if (ack) begin
                        state    <= dma_bus_pkg::TERM;
                        pas      <= 1'b0;
                        pds      <= 1'b0;
                        fifo_pop <= 1'b1;
                        step     <= 1'b1;
                    end
                end
                dma_bus_pkg::TERM: begin
                    state <= dma_bus_pkg::OWN;
                end
                dma_bus_pkg::RELEASE: begin
                    if (!grant) begin
                        state <= dma_bus_pkg::IDLE;
                    end
                end
                default: begin
                    state <= dma_bus_pkg::IDLE;
                end
            endcase
        end
    end

    // set once the packer and fifo are both drained, held until flush drops
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            stop_flush <= 1'b0;
        end else if (!flush_req) begin
            stop_flush <= 1'b0;
        end else if (!pending_half && fifo_empty) begin
            stop_flush <= 1'b1;
        end
    end

    a_pds_inside_pas: assert property (
        @(posedge BCLK) disable iff (!CCRESET_) pds |-> pas
    );

    a_pop_has_data: assert property (
        @(posedge BCLK) disable iff (!CCRESET_) fifo_pop |-> !fifo_empty
    );

    // request and ownership never overlap on the bus
    a_req_ack_apart: assert property (
        @(posedge BCLK) disable iff (!CCRESET_) !(breq && bgack)
    );

endmodule

/* source/dma_fifo_pkg.sv */
// SCSI-side and FIFO definitions for the DMA engine
// sizes of the long-word FIFO, the SCSI half word and the transfer counter
package dma_fifo_pkg;

    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // the SCSI side delivers 16 bits at a time
    localparam int HALF_W = 16;

    // transfer length in long words
    localparam int CNT_W = 16;

endpackage

/* source/dma_bus_pkg.sv */
// CPU-side bus definitions for the SCSI-to-memory DMA engine
// holds the bus widths, the DSACK port-size code and the bus-master states
// modules refer to these by scoped name
package dma_bus_pkg;

    // 32-bit memory port only
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // byte step between consecutive long words
    localparam logic [ADDR_W-1:0] ADDR_STEP = 32'd4;

    // {dsack1_n, dsack0_n} as driven by a 32-bit port
    localparam logic [1:0] DSACK_32 = 2'b00;

    // bus-master sequence of the write engine
    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAIT_GNT,
        OWN,
        ADDR,
        DATA,
        TERM,
        RELEASE
    } cpu_state_t;

endpackage
